/* verilog.f */
hdl/ic_pkg.sv
hdl/ic_req_route.sv
hdl/ic_rsp_tracker.sv
hdl/ic_error_rsp.sv
hdl/ic_rsp_select.sv
hdl/ic_top.sv
tests/ic_top_assertions.sv
tests/ic_top_tb.sv

/* tests/ic_top_tb.sv */
/*
 * Interconnect testbench
 * ROM and RAM models behind the DUT, directed tests on the CPU port
 */
`timescale 1ns/100ps
`default_nettype none

module ic_top_tb;

    localparam int  CLK_PERIOD     = 4;
    localparam int  TIMEOUT_CYCLES = 50;              // Per wait loop
    localparam time ROM_DELAY      = 1 * CLK_PERIOD - CLK_PERIOD / 2;
    localparam time RAM_DELAY      = 3 * CLK_PERIOD - CLK_PERIOD / 2;

    logic                      g_clk = 1'b0;
    logic                      i_rst_n;
    logic                      i_cpu_req;
    logic                      i_cpu_wen;
    logic [ic_pkg::STRB_W-1:0] i_cpu_strb;
    logic [ic_pkg::DATA_W-1:0] i_cpu_wdata;
    logic [ic_pkg::ADDR_W-1:0] i_cpu_addr;
    logic                      i_cpu_ack;
    wire                       o_cpu_gnt;
    wire                       o_cpu_recv;
    wire                       o_cpu_error;
    wire  [ic_pkg::DATA_W-1:0] o_cpu_rdata;
    wire                       o_rom_req;
    wire                       o_rom_wen;
    wire  [ic_pkg::STRB_W-1:0] o_rom_strb;
    wire  [ic_pkg::DATA_W-1:0] o_rom_wdata;
    wire  [ic_pkg::ADDR_W-1:0] o_rom_addr;
    wire                       o_rom_ack;
    logic                      i_rom_gnt   = 1'b1;  // Grants at once
    logic                      i_rom_recv  = 1'b0;
    logic                      i_rom_error = 1'b0;
    logic [ic_pkg::DATA_W-1:0] i_rom_rdata = '0;
    wire                       o_ram_req;
    wire                       o_ram_wen;
    wire  [ic_pkg::STRB_W-1:0] o_ram_strb;
    wire  [ic_pkg::DATA_W-1:0] o_ram_wdata;
    wire  [ic_pkg::ADDR_W-1:0] o_ram_addr;
    wire                       o_ram_ack;
    logic                      i_ram_gnt   = 1'b1;
    logic                      i_ram_recv  = 1'b0;
    logic                      i_ram_error = 1'b0;
    logic [ic_pkg::DATA_W-1:0] i_ram_rdata = '0;

    logic [31:0] lfsr_state;
    logic [31:0] ram_mem [64];      // RAM model storage
    logic [31:0] rom_data_q [$];    // ROM responses in order
    time         rom_due_q [$];     // Time each may be shown
    logic [31:0] ram_data_q [$];
    time         ram_due_q [$];
    logic [31:0] rsp_data_q [$];    // Responses seen by the CPU
    logic [31:0] rsp_err_q [$];
    logic [31:0] exp_data_q [$];    // Expected, in issue order
    logic [31:0] exp_err_q [$];
    int          rom_req_count = 0; // Accepted at each model
    int          ram_req_count = 0;
    int          error_count   = 0;
    int          check_count   = 0;
    int          test_count    = 0;
    int          test_errors_at_start;
    string       test_name;

    ic_top u_dut (
        .g_clk       (g_clk),
        .i_rst_n     (i_rst_n),
        .i_cpu_req   (i_cpu_req),
        .i_cpu_wen   (i_cpu_wen),
        .i_cpu_strb  (i_cpu_strb),
        .i_cpu_wdata (i_cpu_wdata),
        .i_cpu_addr  (i_cpu_addr),
        .i_cpu_ack   (i_cpu_ack),
        .o_cpu_gnt   (o_cpu_gnt),
        .o_cpu_recv  (o_cpu_recv),
        .o_cpu_error (o_cpu_error),
        .o_cpu_rdata (o_cpu_rdata),
        .o_rom_req   (o_rom_req),
        .o_rom_wen   (o_rom_wen),
        .o_rom_strb  (o_rom_strb),
        .o_rom_wdata (o_rom_wdata),
        .o_rom_addr  (o_rom_addr),
        .o_rom_ack   (o_rom_ack),
        .i_rom_gnt   (i_rom_gnt),
        .i_rom_recv  (i_rom_recv),
        .i_rom_error (i_rom_error),
        .i_rom_rdata (i_rom_rdata),
        .o_ram_req   (o_ram_req),
        .o_ram_wen   (o_ram_wen),
        .o_ram_strb  (o_ram_strb),
        .o_ram_wdata (o_ram_wdata),
        .o_ram_addr  (o_ram_addr),
        .o_ram_ack   (o_ram_ack),
        .i_ram_gnt   (i_ram_gnt),
        .i_ram_recv  (i_ram_recv),
        .i_ram_error (i_ram_error),
        .i_ram_rdata (i_ram_rdata)
    );

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // Initial RAM word, built from the full byte address
    function automatic logic [31:0] ram_fill(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hC3C3_5A5A;
    endfunction

    // ------------------------------------------------------------------------
    // Peripheral models accept at posedge and drive at negedge
    // ------------------------------------------------------------------------

    initial begin
        for (int i = 0; i < 64; i++) begin
            ram_mem[i] = ram_fill(32'h2000_0000 | (i << 2));
        end
    end

    always @(posedge g_clk) begin
        if (o_rom_ack && i_rom_recv) begin                  // Head response taken
            void'(rom_data_q.pop_front());
            void'(rom_due_q.pop_front());
        end
        if (o_rom_req && i_rom_gnt) begin
            rom_req_count++;
            // Write fields fan out straight from the CPU
            check_value("rom wen", {31'b0, i_cpu_wen}, {31'b0, o_rom_wen});
            check_value("rom strb", {28'b0, i_cpu_strb}, {28'b0, o_rom_strb});
            check_value("rom wdata", i_cpu_wdata, o_rom_wdata);
            rom_data_q.push_back(o_rom_addr ^ 32'hA5A5_0000);
            rom_due_q.push_back($time + ROM_DELAY);
        end
    end

    always @(posedge g_clk) begin
        if (o_ram_ack && i_ram_recv) begin
            void'(ram_data_q.pop_front());
            void'(ram_due_q.pop_front());
        end
        if (o_ram_req && i_ram_gnt) begin
            ram_req_count++;
            if (o_ram_wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (o_ram_strb[b]) begin                // Byte lane write
                        ram_mem[o_ram_addr[7:2]][8*b +: 8] = o_ram_wdata[8*b +: 8];
                    end
                end
                ram_data_q.push_back(32'h0);                // Writes answer zero
            end else begin
                ram_data_q.push_back(ram_mem[o_ram_addr[7:2]]);
            end
            ram_due_q.push_back($time + RAM_DELAY);
        end
    end

    always @(negedge g_clk) begin
        i_rom_recv  = (rom_data_q.size() > 0) && ($time >= rom_due_q[0]);
        i_rom_rdata = i_rom_recv ? rom_data_q[0] : '0;
        i_ram_recv  = (ram_data_q.size() > 0) && ($time >= ram_due_q[0]);
        i_ram_rdata = i_ram_recv ? ram_data_q[0] : '0;
    end

    // CPU side response capture
    always @(posedge g_clk) begin
        if (o_cpu_recv && i_cpu_ack) begin
            rsp_data_q.push_back(o_cpu_rdata);
            rsp_err_q.push_back({31'b0, o_cpu_error});
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] get_random(input int nbits);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};            // One step per bit
        end
        return value;
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = error_count;
        test_count++;
    endtask

    task automatic finish_test();
        $display("%s finished with %0d errors", test_name, error_count - test_errors_at_start);
    endtask

    task automatic drive_request(input logic [31:0] addr, input logic wen,
                                 input logic [3:0] strb, input logic [31:0] wdata);
        @(negedge g_clk);
        i_cpu_req   = 1'b1;
        i_cpu_addr  = addr;
        i_cpu_wen   = wen;
        i_cpu_strb  = strb;
        i_cpu_wdata = wdata;
    endtask

    // Returns just after the edge that accepted the request
    task automatic wait_grant();
        int   waited;
        logic granted;
        waited  = 0;
        granted = 1'b0;
        while (!granted && waited < TIMEOUT_CYCLES) begin
            @(posedge g_clk);
            if (o_cpu_gnt) begin
                granted = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!granted) begin
            $display("%s: no grant for address %h", test_name, i_cpu_addr);
            error_count++;
        end
    endtask

    task automatic issue_request(input logic [31:0] addr, input logic wen,
                                 input logic [3:0] strb, input logic [31:0] wdata);
        drive_request(addr, wen, strb, wdata);
        wait_grant();
    endtask

    task automatic release_request();
        @(negedge g_clk);
        i_cpu_req = 1'b0;
        i_cpu_wen = 1'b0;
    endtask

    task automatic expect_response(input logic [31:0] data, input logic err);
        exp_data_q.push_back(data);
        exp_err_q.push_back({31'b0, err});
    endtask

    // Wait for all expected responses, then compare in order
    task automatic drain_and_compare();
        int          waited;
        logic [31:0] exp_word;
        logic [31:0] got_word;
        waited = 0;
        while (rsp_data_q.size() < exp_data_q.size() && waited < TIMEOUT_CYCLES) begin
            @(negedge g_clk);
            waited++;
        end
        if (rsp_data_q.size() != exp_data_q.size()) begin
            $display("%s: expected %0d responses but saw %0d", test_name,
                     exp_data_q.size(), rsp_data_q.size());
            error_count++;
        end
        while (exp_data_q.size() > 0 && rsp_data_q.size() > 0) begin
            exp_word = exp_data_q.pop_front();
            got_word = rsp_data_q.pop_front();
            check_value("rdata", exp_word, got_word);
            exp_word = exp_err_q.pop_front();
            got_word = rsp_err_q.pop_front();
            check_value("error", exp_word, got_word);
        end
        exp_data_q.delete();
        exp_err_q.delete();
        rsp_data_q.delete();
        rsp_err_q.delete();
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic read_rom();
        logic [31:0] offset;
        logic [31:0] addr;
        logic [31:0] strb;
        logic [31:0] wdata;
        start_test("rom_read");
        offset = get_random(12);                       // Word inside 16 KB window
        strb   = get_random(4);                        // Ignored on a read
        wdata  = get_random(32);
        addr   = 32'h1000_0000 | (offset << 2);
        expect_response(addr ^ 32'hA5A5_0000, 1'b0);
        issue_request(addr, 1'b0, strb[3:0], wdata);
        release_request();
        drain_and_compare();
        finish_test();
    endtask

    task automatic write_read_ram();
        logic [31:0] index;
        logic [31:0] wdata;
        logic [31:0] addr;
        logic [31:0] mask;
        start_test("ram_write_read");
        index = get_random(5);                         // Lower half of model
        wdata = get_random(32);
        addr  = 32'h2000_0000 | (index << 2);
        mask  = 32'h00FF_FF00;                         // Lanes 1 and 2
        expect_response(32'h0, 1'b0);
        expect_response((ram_fill(addr) & ~mask) | (wdata & mask), 1'b0);
        issue_request(addr, 1'b1, 4'b0110, wdata);
        issue_request(addr, 1'b0, 4'hF, 32'h0);
        release_request();
        drain_and_compare();
        finish_test();
    endtask

    task automatic access_unmapped();
        int rom_before;
        int ram_before;
        start_test("unmapped");
        rom_before = rom_req_count;
        ram_before = ram_req_count;
        expect_response(32'h0, 1'b1);
        expect_response(32'h0, 1'b1);
        issue_request(32'h1000_4000, 1'b0, 4'hF, 32'h0); // Just past ROM window
        issue_request(32'h3000_0000, 1'b1, 4'hF, 32'hDEAD_BEEF);
        release_request();
        drain_and_compare();
        check_value("rom reqs", rom_before, rom_req_count);
        check_value("ram reqs", ram_before, ram_req_count);
        finish_test();
    endtask

    task automatic mix_back_to_back();
        logic [31:0] value;
        logic [31:0] ram_addr;
        logic [31:0] rom_addr [2];
        start_test("mixed_order");
        value       = get_random(5);
        ram_addr    = 32'h2000_0080 | (value << 2);    // Upper half, never written
        value       = get_random(12);
        rom_addr[0] = 32'h1000_0000 | (value << 2);
        value       = get_random(12);
        rom_addr[1] = 32'h1000_0000 | (value << 2);
        expect_response(ram_fill(ram_addr), 1'b0);
        expect_response(rom_addr[0] ^ 32'hA5A5_0000, 1'b0);
        expect_response(rom_addr[1] ^ 32'hA5A5_0000, 1'b0);
        issue_request(ram_addr, 1'b0, 4'hF, 32'h0);
        issue_request(rom_addr[0], 1'b0, 4'hF, 32'h0);
        issue_request(rom_addr[1], 1'b0, 4'hF, 32'h0);
        release_request();
        drain_and_compare();
        finish_test();
    endtask

    task automatic hold_back_pressure();
        logic [31:0] value;
        logic [31:0] addr;
        start_test("back_pressure");
        @(negedge g_clk);
        i_cpu_ack = 1'b0;                              // Hold every response
        for (int k = 0; k < 3; k++) begin
            value = get_random(12);
            addr  = 32'h1000_0000 | (value << 2);
            expect_response(addr ^ 32'hA5A5_0000, 1'b0);
            issue_request(addr, 1'b0, 4'hF, 32'h0);
        end
        value = get_random(12);
        addr  = 32'h1000_0000 | (value << 2);
        expect_response(addr ^ 32'hA5A5_0000, 1'b0);
        drive_request(addr, 1'b0, 4'hF, 32'h0);        // One more than fits
        repeat (5) begin
            @(posedge g_clk);
            check_value("gnt while full", 32'h0, {31'b0, o_cpu_gnt});
            check_value("rom req while full", 32'h0, {31'b0, o_rom_req});
        end
        @(negedge g_clk);
        i_cpu_ack = 1'b1;
        wait_grant();
        release_request();
        drain_and_compare();
        finish_test();
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_cpu_req   = 1'b0;
        i_cpu_wen   = 1'b0;
        i_cpu_strb  = '0;
        i_cpu_wdata = '0;
        i_cpu_addr  = '0;
        i_cpu_ack   = 1'b0;
        lfsr_state  = 32'd86576;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        i_rst_n   = 1'b1;
        i_cpu_ack = 1'b1;                              // Take responses at once
        read_rom();
        write_read_ram();
        access_unmapped();
        mix_back_to_back();
        hold_back_pressure();
        if (u_dut.u_assertions.failures != 0) begin
            $display("%0d bound assertions failed", u_dut.u_assertions.failures);
            error_count++;
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ic_top_assertions.sv */
/*
 * Interconnect port assertions
 * Response hold, exclusive target requests and grant only with request
 */
`timescale 1ns/100ps
`default_nettype none

module ic_top_assertions (
    input wire                      g_clk,
    input wire                      i_rst_n,
    input wire                      i_cpu_req,
    input wire                      i_cpu_ack,
    input wire                      o_cpu_gnt,
    input wire                      o_cpu_recv,
    input wire                      o_cpu_error,
    input wire [ic_pkg::DATA_W-1:0] o_cpu_rdata,
    input wire                      o_rom_req,
    input wire                      o_ram_req
);

    int failures = 0;   // Failed assertion count

    // Response held until acked
    assert property (@(posedge g_clk) disable iff (!i_rst_n)
        (o_cpu_recv && !i_cpu_ack) |=>
            (o_cpu_recv && $stable(o_cpu_error) && $stable(o_cpu_rdata)))
        else begin
            failures++;
            $error("CPU response changed before ack");
        end

    assert property (@(posedge g_clk) disable iff (!i_rst_n) !(o_rom_req && o_ram_req))
        else begin
            failures++;
            $error("ROM and RAM requested together");
        end

    assert property (@(posedge g_clk) disable iff (!i_rst_n) o_cpu_gnt |-> i_cpu_req)
        else begin
            failures++;
            $error("CPU grant without request");
        end

endmodule

bind ic_top ic_top_assertions u_assertions (
    .g_clk       (g_clk),
    .i_rst_n     (i_rst_n),
    .i_cpu_req   (i_cpu_req),
    .i_cpu_ack   (i_cpu_ack),
    .o_cpu_gnt   (o_cpu_gnt),
    .o_cpu_recv  (o_cpu_recv),
    .o_cpu_error (o_cpu_error),
    .o_cpu_rdata (o_cpu_rdata),
    .o_rom_req   (o_rom_req),
    .o_ram_req   (o_ram_req)
);

`default_nettype wire

/* hdl/ic_top.sv */
/*
 * Memory interconnect, data side
 * Routes CPU requests to ROM, RAM or an error responder by address
 * and returns responses in the order the requests were accepted
 */
`timescale 1ns/100ps
`default_nettype none

module ic_top #(
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MATCH = 32'h1000_0000,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MASK  = 32'hFFFF_C000,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MATCH = 32'h2000_0000,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MASK  = 32'hFFFF_0000,
    parameter int                        MAX_REQUESTS  = 3  // Outstanding limit
) (
    input  wire                       g_clk,
    input  wire                       i_rst_n,
    // CPU port
    input  wire                       i_cpu_req,
    input  wire                       i_cpu_wen,
    input  wire  [ic_pkg::STRB_W-1:0] i_cpu_strb,
    input  wire  [ic_pkg::DATA_W-1:0] i_cpu_wdata,
    input  wire  [ic_pkg::ADDR_W-1:0] i_cpu_addr,
    input  wire                       i_cpu_ack,
    output wire                       o_cpu_gnt,
    output wire                       o_cpu_recv,
    output wire                       o_cpu_error,
    output wire  [ic_pkg::DATA_W-1:0] o_cpu_rdata,
    // ROM port
    output wire                       o_rom_req,
    output wire                       o_rom_wen,
    output wire  [ic_pkg::STRB_W-1:0] o_rom_strb,
    output wire  [ic_pkg::DATA_W-1:0] o_rom_wdata,
    output wire  [ic_pkg::ADDR_W-1:0] o_rom_addr,
    output wire                       o_rom_ack,
    input  wire                       i_rom_gnt,
    input  wire                       i_rom_recv,
    input  wire                       i_rom_error,
    input  wire  [ic_pkg::DATA_W-1:0] i_rom_rdata,
    // RAM port
    output wire                       o_ram_req,
    output wire                       o_ram_wen,
    output wire  [ic_pkg::STRB_W-1:0] o_ram_strb,
    output wire  [ic_pkg::DATA_W-1:0] o_ram_wdata,
    output wire  [ic_pkg::ADDR_W-1:0] o_ram_addr,
    output wire                       o_ram_ack,
    input  wire                       i_ram_gnt,
    input  wire                       i_ram_recv,
    input  wire                       i_ram_error,
    input  wire  [ic_pkg::DATA_W-1:0] i_ram_rdata
);

    wire                       ready;      // Tracker has room
    wire                       push;
    wire [ic_pkg::ROUTE_W-1:0] push_route;
    wire                       pop;
    wire                       head_valid;
    wire [ic_pkg::ROUTE_W-1:0] head_route;
    wire                       err_req;
    wire                       err_gnt;
    wire                       err_recv;
    wire                       err_ack;

    // Write fields go to both ports, req picks the target
    assign o_rom_wen   = i_cpu_wen;
    assign o_rom_strb  = i_cpu_strb;
    assign o_rom_wdata = i_cpu_wdata;
    assign o_rom_addr  = i_cpu_addr;
    assign o_ram_wen   = i_cpu_wen;
    assign o_ram_strb  = i_cpu_strb;
    assign o_ram_wdata = i_cpu_wdata;
    assign o_ram_addr  = i_cpu_addr;

    // ------------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------------

    ic_req_route #(
        .MAP_ROM_MATCH (MAP_ROM_MATCH),
        .MAP_ROM_MASK  (MAP_ROM_MASK),
        .MAP_RAM_MATCH (MAP_RAM_MATCH),
        .MAP_RAM_MASK  (MAP_RAM_MASK)
    ) u_req_route (
        .i_cpu_req    (i_cpu_req),
        .i_cpu_addr   (i_cpu_addr),
        .i_ready      (ready),
        .i_rom_gnt    (i_rom_gnt),
        .i_ram_gnt    (i_ram_gnt),
        .i_err_gnt    (err_gnt),
        .o_rom_req    (o_rom_req),
        .o_ram_req    (o_ram_req),
        .o_err_req    (err_req),
        .o_cpu_gnt    (o_cpu_gnt),
        .o_push       (push),
        .o_push_route (push_route)
    );

    ic_rsp_tracker #(
        .MAX_REQUESTS (MAX_REQUESTS)
    ) u_rsp_tracker (
        .g_clk        (g_clk),
        .i_rst_n      (i_rst_n),
        .i_push       (push),
        .i_push_route (push_route),
        .i_pop        (pop),
        .o_head_valid (head_valid),
        .o_head_route (head_route),
        .o_ready      (ready)
    );

    // ------------------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------------------

    // Error flag equals recv, the selector derives it itself
    ic_error_rsp #(
        .MAX_REQUESTS (MAX_REQUESTS)
    ) u_error_rsp (
        .g_clk   (g_clk),
        .i_rst_n (i_rst_n),
        .i_req   (err_req),
        .i_ack   (err_ack),
        .o_gnt   (err_gnt),
        .o_recv  (err_recv),
        .o_error ()
    );

    ic_rsp_select u_rsp_select (
        .i_head_valid (head_valid),
        .i_head_route (head_route),
        .i_rom_recv   (i_rom_recv),
        .i_rom_error  (i_rom_error),
        .i_rom_rdata  (i_rom_rdata),
        .i_ram_recv   (i_ram_recv),
        .i_ram_error  (i_ram_error),
        .i_ram_rdata  (i_ram_rdata),
        .i_err_recv   (err_recv),
        .i_cpu_ack    (i_cpu_ack),
        .o_cpu_recv   (o_cpu_recv),
        .o_cpu_error  (o_cpu_error),
        .o_cpu_rdata  (o_cpu_rdata),
        .o_rom_ack    (o_rom_ack),
        .o_ram_ack    (o_ram_ack),
        .o_err_ack    (err_ack),
        .o_pop        (pop)
    );

endmodule

`default_nettype wire

/* hdl/ic_rsp_select.sv */
/*
 * Response selector
 * Passes the response of the oldest outstanding route to the CPU,
 * steers the CPU ack back to that route and pops the tracker
 */
`timescale 1ns/100ps
`default_nettype none

module ic_rsp_select (
    input  wire                          i_head_valid,
    input  wire  [ic_pkg::ROUTE_W-1:0]   i_head_route,
    input  wire                          i_rom_recv,
    input  wire                          i_rom_error,
    input  wire  [ic_pkg::DATA_W-1:0]    i_rom_rdata,
    input  wire                          i_ram_recv,
    input  wire                          i_ram_error,
    input  wire  [ic_pkg::DATA_W-1:0]    i_ram_rdata,
    input  wire                          i_err_recv,   // Error responder pending
    input  wire                          i_cpu_ack,
    output logic                         o_cpu_recv,
    output logic                         o_cpu_error,
    output logic [ic_pkg::DATA_W-1:0]    o_cpu_rdata,
    output logic                         o_rom_ack,
    output logic                         o_ram_ack,
    output logic                         o_err_ack,
    output logic                         o_pop         // Head response done
);

    logic                      sel_recv;
    logic                      sel_error;
    logic [ic_pkg::DATA_W-1:0] sel_rdata;

    // Mux on the head route
    always_comb begin
        sel_recv  = 1'b0;
        sel_error = 1'b0;
        sel_rdata = '0;
        case (i_head_route)
            ic_pkg::ROUTE_ROM: begin
                sel_recv  = i_rom_recv;
                sel_error = i_rom_error;
                sel_rdata = i_rom_rdata;
            end
            ic_pkg::ROUTE_RAM: begin
                sel_recv  = i_ram_recv;
                sel_error = i_ram_error;
                sel_rdata = i_ram_rdata;
            end
            ic_pkg::ROUTE_ERR: begin
                sel_recv  = i_err_recv;
                sel_error = i_err_recv;   // Every answer is an error, data zero
            end
            default: sel_recv = 1'b0;     // Unused code
        endcase
    end

    assign o_cpu_recv  = i_head_valid && sel_recv;
    assign o_cpu_error = i_head_valid && sel_error;
    assign o_cpu_rdata = i_head_valid ? sel_rdata : '0;

    assign o_rom_ack = i_head_valid && (i_head_route == ic_pkg::ROUTE_ROM) && i_cpu_ack;
    assign o_ram_ack = i_head_valid && (i_head_route == ic_pkg::ROUTE_RAM) && i_cpu_ack;
    assign o_err_ack = i_head_valid && (i_head_route == ic_pkg::ROUTE_ERR) && i_cpu_ack;

    assign o_pop = o_cpu_recv && i_cpu_ack;  // Response handshake completes

endmodule

`default_nettype wire

/* hdl/ic_error_rsp.sv */
/*
 * Error responder
 * Accepts requests that map nowhere and answers each with an error
 */
`timescale 1ns/100ps
`default_nettype none

module ic_error_rsp #(
    parameter int MAX_REQUESTS = 3
) (
    input  wire   g_clk,
    input  wire   i_rst_n,
    input  wire   i_req,    // Unmapped request
    input  wire   i_ack,    // Response taken
    output logic  o_gnt,    // Request accepted
    output logic  o_recv,   // Response pending
    output logic  o_error   // Always an error response
);

    localparam int CNT_W = $clog2(MAX_REQUESTS + 1);

    localparam logic [CNT_W-1:0] FULL = CNT_W'(MAX_REQUESTS);

    logic [CNT_W-1:0] pending;  // Accepted but not yet answered
    logic             done;     // Response handshake this cycle

    assign o_gnt = i_req && (pending != FULL);
    assign done  = o_recv && i_ack;

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending <= '0;
        end else begin
            case ({o_gnt, done})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;      // Both or neither
            endcase
        end
    end

    // Response held until every pending request is acked
    assign o_recv  = (pending != '0);
    assign o_error = o_recv;

endmodule

`default_nettype wire

/* hdl/ic_rsp_tracker.sv */
/*
 * Response ordering tracker
 * Circular queue of route codes, one per accepted request, so that
 * responses are steered back to the CPU in acceptance order
 */
`timescale 1ns/100ps
`default_nettype none

module ic_rsp_tracker #(
    parameter int MAX_REQUESTS = 3
) (
    input  wire                          g_clk,
    input  wire                          i_rst_n,
    input  wire                          i_push,       // Request accepted
    input  wire  [ic_pkg::ROUTE_W-1:0]   i_push_route, // Its responder
    input  wire                          i_pop,        // Head response taken
    output logic                         o_head_valid, // Something outstanding
    output logic [ic_pkg::ROUTE_W-1:0]   o_head_route, // Oldest owner
    output logic                         o_ready       // Not full
);

    localparam int PTR_W = (MAX_REQUESTS > 1) ? $clog2(MAX_REQUESTS) : 1;
    localparam int CNT_W = $clog2(MAX_REQUESTS + 1);

    localparam logic [PTR_W-1:0] LAST = PTR_W'(MAX_REQUESTS - 1); // Wrap point
    localparam logic [CNT_W-1:0] FULL = CNT_W'(MAX_REQUESTS);

    logic [ic_pkg::ROUTE_W-1:0] route_q [MAX_REQUESTS]; // Route per slot
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;   // Outstanding requests
    logic                       do_push;
    logic                       do_pop;

    assign do_push = i_push && o_ready;       // Ignore pushes when full
    assign do_pop  = i_pop && o_head_valid;   // Ignore pops when empty

    // ------------------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Idle or push with pop
            endcase
        end
    end

    // Slot storage
    always_ff @(posedge g_clk) begin
        if (do_push) begin
            route_q[wr_ptr] <= i_push_route;
        end
    end

    assign o_head_valid = (count != '0);
    assign o_head_route = route_q[rd_ptr];    // Only meaningful when valid
    assign o_ready      = (count != FULL);

endmodule

`default_nettype wire

/* hdl/ic_req_route.sv */
/*
 * Request router
 * Decodes the CPU address against the memory map, raises the request
 * of the matching target and forms the CPU grant and tracker push
 */
`timescale 1ns/100ps
`default_nettype none

module ic_req_route #(
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MATCH = 32'h1000_0000,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_ROM_MASK  = 32'hFFFF_C000,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MATCH = 32'h2000_0000,
    parameter logic [ic_pkg::ADDR_W-1:0] MAP_RAM_MASK  = 32'hFFFF_0000
) (
    input  wire                          i_cpu_req,    // CPU request strobe
    input  wire  [ic_pkg::ADDR_W-1:0]    i_cpu_addr,   // CPU request address
    input  wire                          i_ready,      // Tracker has room
    input  wire                          i_rom_gnt,    // ROM accepts
    input  wire                          i_ram_gnt,    // RAM accepts
    input  wire                          i_err_gnt,    // Error responder accepts
    output logic                         o_rom_req,
    output logic                         o_ram_req,
    output logic                         o_err_req,
    output logic                         o_cpu_gnt,    // Request accepted
    output logic                         o_push,       // Record in tracker
    output logic [ic_pkg::ROUTE_W-1:0]   o_push_route  // Owner of accepted request
);

    logic                       rom_hit;  // Address inside ROM window
    logic                       ram_hit;  // Address inside RAM window
    logic [ic_pkg::ROUTE_W-1:0] route;    // Decoded target
    logic                       sel_gnt;  // Grant of decoded target
    logic                       launch;   // Request allowed out this cycle

    assign rom_hit = (i_cpu_addr & MAP_ROM_MASK) == MAP_ROM_MATCH;
    assign ram_hit = (i_cpu_addr & MAP_RAM_MASK) == MAP_RAM_MATCH;

    // ROM wins if the two windows ever overlap
    always_comb begin
        if (rom_hit) begin
            route = ic_pkg::ROUTE_ROM;
        end else if (ram_hit) begin
            route = ic_pkg::ROUTE_RAM;
        end else begin
            route = ic_pkg::ROUTE_ERR; // Maps nowhere
        end
    end

    assign launch    = i_cpu_req && i_ready;      // Single gating point
    assign o_rom_req = launch && (route == ic_pkg::ROUTE_ROM);
    assign o_ram_req = launch && (route == ic_pkg::ROUTE_RAM);
    assign o_err_req = launch && (route == ic_pkg::ROUTE_ERR);

    always_comb begin
        case (route)
            ic_pkg::ROUTE_ROM: sel_gnt = i_rom_gnt;
            ic_pkg::ROUTE_RAM: sel_gnt = i_ram_gnt;
            default:           sel_gnt = i_err_gnt;
        endcase
    end

    assign o_cpu_gnt    = launch && sel_gnt;     // Same cycle as req
    assign o_push       = o_cpu_gnt;             // Every accept is tracked
    assign o_push_route = route;

endmodule

`default_nettype wire

/* hdl/ic_pkg.sv */
/*
 * Interconnect shared definitions
 * Bus widths and the route codes that tag each accepted request
 */
`default_nettype none

package ic_pkg;

    // ------------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------------

    localparam int ADDR_W = 32;         // Request address
    localparam int DATA_W = 32;         // Read and write data
    localparam int STRB_W = DATA_W / 8; // One strobe per byte lane

    // ------------------------------------------------------------------------
    // Route codes
    // ------------------------------------------------------------------------

    // Which responder owns an accepted request
    localparam int ROUTE_W = 2;

    localparam logic [ROUTE_W-1:0] ROUTE_ROM = 2'd0; // ROM port
    localparam logic [ROUTE_W-1:0] ROUTE_RAM = 2'd1; // RAM port
    localparam logic [ROUTE_W-1:0] ROUTE_ERR = 2'd2; // Internal error responder

endpackage

`default_nettype wire
